// File: bridge/rackctl_bridge_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_bridge_ctrl
    import wb_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 600,
    parameter int TX_CREDITS     = 1
) (
    input  wire          sysclk_i,
    input  wire          rst_n_i,
    input  wire wb_req_t gtp_req_i,
    input  wire wb_req_t dbg_req_i,
    output logic         capture_o,
    output wb_master_e   sel_o,
    output logic         cmd_valid_o,
    input  wire          credit_i,
    input  wire          resp_valid_i,
    input  wire          resp_err_i,
    output logic         load_resp_o,
    output logic         load_err_o,
    output logic         gtp_ack_o,
    output logic         dbg_ack_o,
    input  wire          err_rst_i,
    output logic         bridge_err_o
);

    localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int CRD_W = $clog2(TX_CREDITS + 1);

    typedef enum logic [2:0] {
        IDLE,
        ACCEPT,
        ISSUE,
        WAIT_RESP,
        ACK
    } state_e;

    state_e           state_q;
    state_e           state_d;
    wb_master_e       sel_q;
    logic [CRD_W-1:0] credit_cnt;
    logic [TMO_W-1:0] tmo_cnt_q;
    logic             load_resp_q;
    logic             load_err_q;
    logic             err_q;
    logic             gtp_req;
    logic             dbg_req;
    logic             load_pending;
    logic             timeout;

    assign gtp_req      = gtp_req_i.cyc & gtp_req_i.stb;
    assign dbg_req      = dbg_req_i.cyc & dbg_req_i.stb;
    assign load_pending = load_resp_q | load_err_q;
    assign timeout      = (state_q == WAIT_RESP) && !load_pending && !resp_valid_i &&
                          (tmo_cnt_q == TMO_W'(TIMEOUT_CYCLES - 1));

    // a command leaves only with a free serializer slot
    assign cmd_valid_o = (state_q == ISSUE) && (credit_cnt != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (gtp_req || dbg_req) state_d = ACCEPT;
            ACCEPT:    state_d = ISSUE;
            ISSUE:     if (cmd_valid_o) state_d = WAIT_RESP;
            // stay one extra cycle while the data register loads
            WAIT_RESP: if (load_pending) state_d = ACK;
            ACK:       state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            sel_q       <= MST_DBG;
            tmo_cnt_q   <= '0;
            load_resp_q <= 1'b0;
            load_err_q  <= 1'b0;
        end else begin
            state_q <= state_d;

            // fixed priority, gtp first
            if (state_q == IDLE) begin
                if (gtp_req) begin
                    sel_q <= MST_GTP;
                end else if (dbg_req) begin
                    sel_q <= MST_DBG;
                end
            end

            if (cmd_valid_o) begin
                tmo_cnt_q <= '0;
            end else if (state_q == WAIT_RESP && !load_pending) begin
                tmo_cnt_q <= tmo_cnt_q + 1'b1;
            end

            // single-cycle load strobes, one cycle after the outcome is known
            load_resp_q <= 1'b0;
            load_err_q  <= 1'b0;
            if (state_q == WAIT_RESP && !load_pending) begin
                if (resp_valid_i) begin
                    load_resp_q <= !resp_err_i;
                    load_err_q  <= resp_err_i;
                end else if (timeout) begin
                    load_err_q <= 1'b1;
                end
            end
        end
    end

    // serializer credits
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CRD_W'(TX_CREDITS);
        end else if (cmd_valid_o && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_i && !cmd_valid_o) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // sticky error, clear wins over set
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else if (err_rst_i) begin
            err_q <= 1'b0;
        end else if (load_err_q) begin
            err_q <= 1'b1;
        end
    end

    assign capture_o    = (state_q == ACCEPT);
    assign sel_o        = sel_q;
    assign load_resp_o  = load_resp_q;
    assign load_err_o   = load_err_q;
    assign gtp_ack_o    = (state_q == ACK) && (sel_q == MST_GTP);
    assign dbg_ack_o    = (state_q == ACK) && (sel_q == MST_DBG);
    assign bridge_err_o = err_q;

endmodule

`default_nettype wire

// File: bridge/rackctl_rx.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_rx
    import rackctl_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4
) (
    input  wire           sysclk_i,
    input  wire           rst_n_i,
    input  wire           rx_line_i,
    output logic          resp_valid_o,
    output rackctl_resp_t resp_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W = $clog2(RESP_FRAME_BITS);

    logic [1:0]                   sync_q;
    logic                         rx_s;
    logic                         rx_prev_q;
    logic                         busy_q;
    logic [CNT_W-1:0]             clk_cnt_q;
    logic [BIT_W-1:0]             bit_cnt_q;
    logic [RESP_FRAME_BITS-1:0]   shift_q;
    logic [RESP_FRAME_BITS-1:0]   frame;
    logic [RESP_PAYLOAD_BITS-1:0] payload;
    logic                         mid_sample;
    logic                         last_bit;
    logic                         fault;
    logic                         valid_q;
    rackctl_resp_t                resp_q;

    assign rx_s = sync_q[1];

    // count 0 is the cycle the falling edge is seen
    assign mid_sample = busy_q && (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2));
    assign last_bit   = (bit_cnt_q == BIT_W'(RESP_FRAME_BITS - 1));

    // frame as it stands once the current sample is shifted in
    assign frame   = {rx_s, shift_q[RESP_FRAME_BITS-1:1]};
    assign payload = frame[RESP_FRAME_BITS-3:1];

    // bad start, missing stop, or odd parity over payload and parity bit
    assign fault = frame[0] | ~frame[RESP_FRAME_BITS-1] | (^frame[RESP_FRAME_BITS-2:1]);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], rx_line_i};
            rx_prev_q <= rx_s;
            valid_q   <= 1'b0;
            if (!busy_q) begin
                if (rx_prev_q && !rx_s) begin
                    busy_q    <= 1'b1;
                    clk_cnt_q <= CNT_W'(1);
                    bit_cnt_q <= '0;
                end
            end else begin
                if (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end else begin
                    clk_cnt_q <= clk_cnt_q + 1'b1;
                end
                // back to idle at mid stop so the next start edge is not missed
                if (mid_sample && last_bit) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (mid_sample) begin
            shift_q <= frame;
            if (last_bit) begin
                resp_q <= rackctl_resp_t'({payload[RESP_PAYLOAD_BITS-1] | fault,
                                           payload[RESP_PAYLOAD_BITS-2:0]});
            end
        end
    end

    assign resp_valid_o = valid_q;
    assign resp_o       = resp_q;

endmodule

`default_nettype wire

// File: bridge/rackctl_tx.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_tx
    import rackctl_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4,
    parameter int TX_CREDITS   = 1
) (
    input  wire               sysclk_i,
    input  wire               rst_n_i,
    input  wire rackctl_cmd_t cmd_i,
    input  wire               cmd_valid_i,
    output logic              credit_o,
    output logic              tx_line_o
);

    localparam int CNT_W  = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W  = $clog2(CMD_FRAME_BITS);
    localparam int PTR_W  = (TX_CREDITS > 1) ? $clog2(TX_CREDITS) : 1;
    localparam int FILL_W = $clog2(TX_CREDITS + 1);

    rackctl_cmd_t              slot_mem [TX_CREDITS];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [FILL_W-1:0]         fill_q;
    logic                      busy_q;
    logic [CNT_W-1:0]          clk_cnt_q;
    logic [BIT_W-1:0]          bit_cnt_q;
    logic [CMD_FRAME_BITS-1:0] shift_q;
    logic                      take_slot;
    logic                      take_direct;
    logic                      push;
    logic                      bit_end;
    logic                      last_bit;
    rackctl_cmd_t              load_cmd;

    // stop, parity, payload, start from msb down
    function automatic logic [CMD_FRAME_BITS-1:0] build_frame(input rackctl_cmd_t cmd);
        build_frame = {1'b1, ^cmd, cmd, 1'b0};
    endfunction

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(TX_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // an idle shifter with empty slots takes the command straight away
    assign take_slot   = !busy_q && (fill_q != '0);
    assign take_direct = !busy_q && (fill_q == '0) && cmd_valid_i;
    assign push        = cmd_valid_i && !take_direct;
    assign load_cmd    = take_slot ? slot_mem[rd_ptr_q] : cmd_i;

    assign bit_end  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt_q == BIT_W'(CMD_FRAME_BITS - 1));

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            slot_mem[wr_ptr_q] <= cmd_i;
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '1;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (take_slot) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !take_slot) begin
                fill_q <= fill_q + 1'b1;
            end else if (take_slot && !push) begin
                fill_q <= fill_q - 1'b1;
            end

            if (take_slot || take_direct) begin
                busy_q    <= 1'b1;
                clk_cnt_q <= '0;
                bit_cnt_q <= '0;
                shift_q   <= build_frame(load_cmd);
            end else if (busy_q) begin
                if (bit_end) begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    // ones fill in behind so the line idles high
                    shift_q   <= {1'b1, shift_q[CMD_FRAME_BITS-1:1]};
                    if (last_bit) begin
                        busy_q <= 1'b0;
                    end
                end else begin
                    clk_cnt_q <= clk_cnt_q + 1'b1;
                end
            end
        end
    end

    // slot frees on the last cycle of the stop bit
    assign credit_o  = busy_q && bit_end && last_bit;
    assign tx_line_o = shift_q[0];

endmodule

`default_nettype wire

// File: bridge/rackctl_txn_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_txn_reg
    import wb_pkg::*;
    import rackctl_pkg::*;
(
    input  wire             sysclk_i,
    input  wire             rst_n_i,
    input  wire wb_req_t    gtp_req_i,
    input  wire wb_req_t    dbg_req_i,
    input  wire wb_master_e sel_i,
    input  wire             capture_i,
    input  wire             load_resp_i,
    input  wire             load_err_i,
    input  wire [31:0]      resp_data_i,
    output rackctl_cmd_t    cmd_o,
    output logic [31:0]     data_o
);

    wb_req_t         req;
    rackctl_opcode_e op_q;
    logic [21:0]     addr_q;
    logic [31:0]     data_q;

    assign req = (sel_i == MST_GTP) ? gtp_req_i : dbg_req_i;

    always_ff @(posedge sysclk_i) begin
        if (capture_i) begin
            op_q   <= req.we ? OP_WRITE : OP_READ;
            addr_q <= req.adr;
        end
    end

    // one data word, first the write data, then the returned or error word
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_q <= '0;
        end else if (capture_i) begin
            data_q <= req.we ? req.dat : 32'h0;
        end else if (load_err_i) begin
            data_q <= '1;
        end else if (load_resp_i) begin
            data_q <= resp_data_i;
        end
    end

    assign cmd_o  = '{op: op_q, addr: addr_q, data: data_q};
    assign data_o = data_q;

endmodule

`default_nettype wire

// File: common/rackctl_pkg.sv
`default_nettype none

package rackctl_pkg;

    // frame opcode, first field of every command
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } rackctl_opcode_e;

    // command payload, sent least significant bit first
    typedef struct packed {
        rackctl_opcode_e op;
        logic [21:0]     addr;
        logic [31:0]     data;
    } rackctl_cmd_t;

    // response payload, err is the far end's status bit
    typedef struct packed {
        logic        err;
        logic [31:0] data;
    } rackctl_resp_t;

    localparam int CMD_PAYLOAD_BITS  = $bits(rackctl_cmd_t);
    localparam int RESP_PAYLOAD_BITS = $bits(rackctl_resp_t);

    // start + payload + even parity + stop
    localparam int CMD_FRAME_BITS  = CMD_PAYLOAD_BITS + 3;
    localparam int RESP_FRAME_BITS = RESP_PAYLOAD_BITS + 3;

endpackage

`default_nettype wire

// File: common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // one Wishbone request, sel lanes are carried but ignored
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [21:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // owner of the current transaction
    typedef enum logic {
        MST_DBG = 1'b0,
        MST_GTP = 1'b1
    } wb_master_e;

endpackage

`default_nettype wire

// File: flist.f
common/rackctl_pkg.sv
common/wb_pkg.sv
bridge/rackctl_bridge_ctrl.sv
bridge/rackctl_txn_reg.sv
bridge/rackctl_tx.sv
bridge/rackctl_rx.sv
verilog/rackctl_wb_bridge_top.sv
tb/tb_clkgen.sv
tb/tb_rackctl_remote.sv
tb/rackctl_checker_checker.sv
tb/tb_rackctl.sv

// File: run.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rackctl -f flist.f -o Vtb_rackctl

./obj_dir/Vtb_rackctl 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

// File: tb/rackctl_checker_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_checker #(
    parameter int TX_CREDITS = 1
) (
    input wire sysclk_i,
    input wire rst_n_i,
    input wire cmd_valid_i,
    input wire credit_i,
    input wire gtp_ack_i,
    input wire dbg_ack_i
);

    int credits_left;

    // free serializer slots as counted from the issue and return pulses
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits_left <= TX_CREDITS;
        end else begin
            credits_left <= credits_left - (cmd_valid_i ? 1 : 0) + (credit_i ? 1 : 0);
        end
    end

    // only the owner of the transaction is acknowledged
    acks_exclusive: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        !(gtp_ack_i && dbg_ack_i))
        else $error("gtp and dbg ack high in the same cycle");

    gtp_ack_pulse: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        gtp_ack_i |=> !gtp_ack_i)
        else $error("gtp ack held longer than one cycle");

    dbg_ack_pulse: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        dbg_ack_i |=> !dbg_ack_i)
        else $error("dbg ack held longer than one cycle");

    credit_guard: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        cmd_valid_i |-> (credits_left > 0))
        else $error("command issued with no serializer credit");

endmodule

bind rackctl_bridge_ctrl rackctl_checker #(.TX_CREDITS(TX_CREDITS)) u_checker (
    .sysclk_i   (sysclk_i),
    .rst_n_i    (rst_n_i),
    .cmd_valid_i(cmd_valid_o),
    .credit_i   (credit_i),
    .gtp_ack_i  (gtp_ack_o),
    .dbg_ack_i  (dbg_ack_o)
);

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/tb_rackctl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rackctl
    import wb_pkg::*;
();

    localparam int CLKS_PER_BIT   = 4;
    localparam int TIMEOUT_CYCLES = 600;
    localparam int ACK_TIMEOUT    = 3000;
    localparam int N_RANDOM       = 200;

    typedef enum logic [1:0] {
        NO_FAULT,
        BAD_PARITY,
        NO_ANSWER
    } fault_e;

    logic        sysclk;
    logic        rst_n;
    wb_req_t     gtp_req;
    wb_req_t     dbg_req;
    wb_rsp_t     gtp_rsp;
    wb_rsp_t     dbg_rsp;
    logic        err_rst;
    logic        bridge_err;
    logic        tx_line;
    logic        rx_line;
    logic        cmd_fault;
    fault_e      fault;
    integer      seed;
    logic [31:0] ref_mem [64];
    logic        ref_err;
    wb_master_e  ack_order [$];
    wb_req_t     acked_req;
    logic [31:0] acked_dat;
    logic [31:0] exp_dat;

    tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clkgen (
        .clk_o  (sysclk),
        .rst_n_o(rst_n)
    );

    rackctl_wb_bridge_top #(
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .TX_CREDITS    (1)
    ) DUT (
        .sysclk_i    (sysclk),
        .rst_n_i     (rst_n),
        .gtp_req_i   (gtp_req),
        .dbg_req_i   (dbg_req),
        .gtp_rsp_o   (gtp_rsp),
        .dbg_rsp_o   (dbg_rsp),
        .err_rst_i   (err_rst),
        .bridge_err_o(bridge_err),
        .tx_line_o   (tx_line),
        .rx_line_i   (rx_line)
    );

    tb_rackctl_remote #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_remote (
        .clk_i        (sysclk),
        .rst_n_i      (rst_n),
        .line_i       (tx_line),
        .line_o       (rx_line),
        .flip_parity_i(fault == BAD_PARITY),
        .silent_i     (fault == NO_ANSWER),
        .cmd_fault_o  (cmd_fault)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // far-end register file and sticky flag in the order the bridge serves them
    function automatic logic [31:0] ref_access(input wb_req_t req, input fault_e flt);
        logic        mapped;
        logic [31:0] result;
        mapped = (req.adr < 22'd64);
        result = '1;
        if (flt != NO_ANSWER && mapped) begin
            if (req.we) begin
                ref_mem[req.adr[5:0]] = req.dat;
            end
            if (flt == NO_FAULT) begin
                result = ref_mem[req.adr[5:0]];
            end
        end
        if (!mapped || flt != NO_FAULT) begin
            ref_err = 1'b1;
        end
        return result;
    endfunction

    task automatic wb_cycle(input wb_master_e mst, input logic we, input logic [21:0] adr,
                            input logic [31:0] dat);
        wb_req_t req;
        logic    acked;
        int      n;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hf};
        @(posedge sysclk);
        #1;
        if (mst == MST_GTP) begin
            gtp_req = req;
        end else begin
            dbg_req = req;
        end
        acked = 1'b0;
        n = 0;
        while (!acked && n < ACK_TIMEOUT) begin
            @(negedge sysclk);
            acked = (mst == MST_GTP) ? gtp_rsp.ack : dbg_rsp.ack;
            n++;
        end
        if (!acked) begin
            fail_run($sformatf("Timeout: master %s got no ack", mst.name()));
        end
        @(posedge sysclk);
        #1;
        if (mst == MST_GTP) begin
            gtp_req = '0;
        end else begin
            dbg_req = '0;
        end
    endtask

    task automatic clear_error();
        @(posedge sysclk);
        #1 err_rst = 1'b1;
        @(posedge sysclk);
        #1 err_rst = 1'b0;
        ref_err = 1'b0;
        @(negedge sysclk);
        check_value("bridge_err_o", 32'(bridge_err), 32'd0);
    endtask

    // every ack is scored against the reference while the request is still held
    always @(negedge sysclk) begin
        if (rst_n && (gtp_rsp.ack || dbg_rsp.ack)) begin
            check_value("gtp_ack & dbg_ack", 32'(gtp_rsp.ack & dbg_rsp.ack), 32'd0);
            acked_req = gtp_rsp.ack ? gtp_req : dbg_req;
            acked_dat = gtp_rsp.ack ? gtp_rsp.dat : dbg_rsp.dat;
            exp_dat   = ref_access(acked_req, fault);
            check_value(gtp_rsp.ack ? "gtp_rsp_o.dat" : "dbg_rsp_o.dat", acked_dat, exp_dat);
            check_value("bridge_err_o", 32'(bridge_err), 32'(ref_err));
            check_value("command frame fault", 32'(cmd_fault), 32'd0);
            ack_order.push_back(gtp_rsp.ack ? MST_GTP : MST_DBG);
        end
    end

    initial begin
        int          n;
        logic [21:0] adr;
        logic [21:0] adr2;
        logic [31:0] w0;
        logic [31:0] w1;
        seed    = 32'hb4ce_7476;
        gtp_req = '0;
        dbg_req = '0;
        err_rst = 1'b0;
        fault   = NO_FAULT;
        ref_err = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = '0;
        end

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge sysclk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            fail_run("Reset was never released");
        end
        @(negedge sysclk);
        check_value("gtp_rsp_o.ack", 32'(gtp_rsp.ack), 32'd0);
        check_value("dbg_rsp_o.ack", 32'(dbg_rsp.ack), 32'd0);
        check_value("tx_line_o", 32'(tx_line), 32'd1);
        check_value("bridge_err_o", 32'(bridge_err), 32'd0);

        // gtp writes and dbg reads back
        for (int i = 0; i < 8; i++) begin
            wb_cycle(MST_GTP, 1'b1, 22'(i * 8 + 3), rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            wb_cycle(MST_DBG, 1'b0, 22'(i * 8 + 3), 32'h0);
        end

        // both masters at once with gtp served first
        ack_order.delete();
        w0 = rand_word();
        fork
            wb_cycle(MST_GTP, 1'b1, 22'd12, w0);
            wb_cycle(MST_DBG, 1'b0, 22'd11, 32'h0);
        join
        check_value("ack count", ack_order.size(), 32'd2);
        check_value("first acked master", 32'(ack_order[0]), 32'(MST_GTP));
        check_value("second acked master", 32'(ack_order[1]), 32'(MST_DBG));

        // unmapped addresses leave the error set until it is cleared
        wb_cycle(MST_GTP, 1'b0, 22'd64, 32'h0);
        wb_cycle(MST_DBG, 1'b1, 22'd100, rand_word());
        wb_cycle(MST_GTP, 1'b0, 22'd3, 32'h0);
        check_value("bridge_err_o", 32'(bridge_err), 32'd1);
        clear_error();
        wb_cycle(MST_DBG, 1'b0, 22'd3, 32'h0);

        fault = BAD_PARITY;
        wb_cycle(MST_DBG, 1'b0, 22'd19, 32'h0);
        fault = NO_FAULT;
        clear_error();

        // one silent far end followed by normal traffic
        fault = NO_ANSWER;
        wb_cycle(MST_GTP, 1'b1, 22'd27, rand_word());
        fault = NO_FAULT;
        wb_cycle(MST_GTP, 1'b1, 22'd27, rand_word());
        wb_cycle(MST_DBG, 1'b0, 22'd27, 32'h0);
        clear_error();

        for (int i = 0; i < N_RANDOM; i++) begin
            w0   = rand_word();
            w1   = rand_word();
            adr  = 22'(rand_word() % 72);
            adr2 = 22'(rand_word() % 72);
            if (w0[3:2] == 2'b11) begin
                fork
                    wb_cycle(MST_GTP, w0[1], adr, w1);
                    wb_cycle(MST_DBG, w0[4], adr2, ~w1);
                join
            end else begin
                wb_cycle(w0[0] ? MST_GTP : MST_DBG, w0[1], adr, w1);
            end
            if (i % 25 == 24) begin
                clear_error();
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_rackctl_remote.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rackctl_remote
    import rackctl_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4
) (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  line_i,
    output logic line_o,
    input  wire  flip_parity_i,
    input  wire  silent_i,
    output logic cmd_fault_o
);

    logic [31:0]               regs [64];
    logic [CMD_FRAME_BITS-1:0] cmd_frame;
    rackctl_cmd_t              cmd;
    rackctl_resp_t             resp;

    // called one half cycle into the start bit, samples near each bit center
    task automatic receive_cmd();
        repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
        cmd_frame[0] = line_i;
        for (int i = 1; i < CMD_FRAME_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            cmd_frame[i] = line_i;
        end
    endtask

    task automatic send_resp(input rackctl_resp_t r, input logic flip);
        logic [RESP_FRAME_BITS-1:0] frame;
        frame = {1'b1, (^r) ^ flip, r, 1'b0};
        for (int i = 0; i < RESP_FRAME_BITS; i++) begin
            @(posedge clk_i);
            #1 line_o = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
        end
    endtask

    // start low, stop high, even parity over payload
    function automatic logic frame_bad(input logic [CMD_FRAME_BITS-1:0] f);
        return f[0] | ~f[CMD_FRAME_BITS-1] | (^f[CMD_FRAME_BITS-2:1]);
    endfunction

    initial begin
        line_o      = 1'b1;
        cmd_fault_o = 1'b0;
        for (int a = 0; a < 64; a++) begin
            regs[a] = '0;
        end
        forever begin
            @(negedge clk_i);
            if (rst_n_i && !line_i) begin
                receive_cmd();
                cmd = rackctl_cmd_t'(cmd_frame[CMD_PAYLOAD_BITS:1]);
                if (frame_bad(cmd_frame)) begin
                    cmd_fault_o = 1'b1;
                end
                // a silent far end drops the command entirely
                if (!silent_i) begin
                    if (cmd.addr < 22'd64) begin
                        if (cmd.op == OP_WRITE) begin
                            regs[cmd.addr[5:0]] = cmd.data;
                        end
                        resp = '{err: 1'b0, data: regs[cmd.addr[5:0]]};
                    end else begin
                        resp = '{err: 1'b1, data: 32'h0};
                    end
                    send_resp(resp, flip_parity_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rackctl_wb_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_wb_bridge_top
    import wb_pkg::*;
    import rackctl_pkg::*;
#(
    parameter int CLKS_PER_BIT   = 4,
    parameter int TIMEOUT_CYCLES = 600,
    parameter int TX_CREDITS     = 1
) (
    input  wire         sysclk_i,
    input  wire         rst_n_i,
    input  wire wb_req_t gtp_req_i,
    input  wire wb_req_t dbg_req_i,
    output wb_rsp_t     gtp_rsp_o,
    output wb_rsp_t     dbg_rsp_o,
    input  wire         err_rst_i,
    output logic        bridge_err_o,
    output logic        tx_line_o,
    input  wire         rx_line_i
);

    logic          capture;
    wb_master_e    sel;
    logic          cmd_valid;
    logic          credit;
    logic          resp_valid;
    rackctl_resp_t resp;
    logic          load_resp;
    logic          load_err;
    logic          gtp_ack;
    logic          dbg_ack;
    rackctl_cmd_t  cmd;
    logic [31:0]   txn_data;

    rackctl_bridge_ctrl #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .TX_CREDITS    (TX_CREDITS)
    ) u_ctrl (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .gtp_req_i   (gtp_req_i),
        .dbg_req_i   (dbg_req_i),
        .capture_o   (capture),
        .sel_o       (sel),
        .cmd_valid_o (cmd_valid),
        .credit_i    (credit),
        .resp_valid_i(resp_valid),
        .resp_err_i  (resp.err),
        .load_resp_o (load_resp),
        .load_err_o  (load_err),
        .gtp_ack_o   (gtp_ack),
        .dbg_ack_o   (dbg_ack),
        .err_rst_i   (err_rst_i),
        .bridge_err_o(bridge_err_o)
    );

    rackctl_txn_reg u_txn_reg (
        .sysclk_i   (sysclk_i),
        .rst_n_i    (rst_n_i),
        .gtp_req_i  (gtp_req_i),
        .dbg_req_i  (dbg_req_i),
        .sel_i      (sel),
        .capture_i  (capture),
        .load_resp_i(load_resp),
        .load_err_i (load_err),
        .resp_data_i(resp.data),
        .cmd_o      (cmd),
        .data_o     (txn_data)
    );

    rackctl_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .TX_CREDITS  (TX_CREDITS)
    ) u_tx (
        .sysclk_i   (sysclk_i),
        .rst_n_i    (rst_n_i),
        .cmd_i      (cmd),
        .cmd_valid_i(cmd_valid),
        .credit_o   (credit),
        .tx_line_o  (tx_line_o)
    );

    rackctl_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .rx_line_i   (rx_line_i),
        .resp_valid_o(resp_valid),
        .resp_o      (resp)
    );

    // both masters see the same data word, only the owner gets ack
    assign gtp_rsp_o = '{ack: gtp_ack, dat: txn_data};
    assign dbg_rsp_o = '{ack: dbg_ack, dat: txn_data};

endmodule

`default_nettype wire
